//--- rtl/tex_pkg.sv
`default_nettype none

package tex_pkg;

    // --------------------------------------------------
    //  image geometry
    // --------------------------------------------------
    localparam int IMG_W      = 16;
    localparam int IMG_H      = 16;
    localparam int PIX_BITS   = 8;
    localparam int POS_BITS   = 4;
    localparam int BLK_X_SIZE = 2;     // log2 tile width
    localparam int BLK_Y_SIZE = 2;     // log2 tile height
    localparam int ADDR_BITS  = 8;
    localparam int FRAC_BITS  = 4;

    typedef logic [PIX_BITS-1:0]  pixel_t;
    typedef logic [POS_BITS-1:0]  pos_t;
    typedef logic [ADDR_BITS-1:0] tex_addr_t;

    // fixed point, 4 fraction bits
    typedef logic signed [7:0]  coeff_t;
    typedef logic signed [11:0] offset_t;
    typedef logic signed [11:0] coord_t;   // 8.4

    typedef enum logic {WR_WAIT_FIRST, WR_FILL} wr_state_t;
    typedef enum logic {GEN_IDLE, GEN_RUN} gen_state_t;

    // tile row | tile col | row in tile | col in tile
    function automatic tex_addr_t tile_addr(input int x, input int y);
        pos_t xp;
        pos_t yp;
        xp = POS_BITS'(x);
        yp = POS_BITS'(y);
        return {yp[POS_BITS-1:BLK_Y_SIZE], xp[POS_BITS-1:BLK_X_SIZE],
                yp[BLK_Y_SIZE-1:0], xp[BLK_X_SIZE-1:0]};
    endfunction

endpackage

`default_nettype wire

//--- rtl/tex_mem_if.sv
`timescale 1ns/1ps
`default_nettype none

interface tex_mem_if
    import tex_pkg::*;
();

    logic      wr_en;
    tex_addr_t wr_addr;
    pixel_t    wr_data;
    logic      rd_en;
    tex_addr_t rd_addr;
    pixel_t    rd_data;     // valid one cycle after rd_en, held otherwise

    modport writer (output wr_en, output wr_addr, output wr_data);
    modport reader (output rd_en, output rd_addr, input rd_data);
    modport mem    (input wr_en, input wr_addr, input wr_data,
                    input rd_en, input rd_addr, output rd_data);

endinterface

`default_nettype wire

//--- rtl/coord_if.sv
`timescale 1ns/1ps
`default_nettype none

interface coord_if
    import tex_pkg::*;
();

    coord_t u;
    coord_t v;
    logic   last;       // final coordinate of the frame
    logic   valid;
    logic   ready;

    modport producer (output u, output v, output last, output valid, input ready);
    modport consumer (input u, input v, input last, input valid, output ready);

endinterface

`default_nettype wire

//--- rtl/texture_writer.sv
`timescale 1ns/1ps
`default_nettype none

module texture_writer
    import tex_pkg::*;
(
    input  wire           clk,
    input  wire           reset,

    input  pixel_t        in_data,
    input  wire           in_first,
    input  wire           in_last,
    input  wire           in_valid,
    output logic          in_ready,

    input  wire           sampling_busy,
    output logic          frame_written,

    tex_mem_if.writer     mem
);

    wr_state_t state;
    pos_t      cur_x;           // position of the next pixel
    pos_t      cur_y;
    pos_t      pix_x;
    pos_t      pix_y;
    logic      accept;
    logic      take;
    logic      line_end;
    logic      frame_end;

    assign in_ready = !sampling_busy;
    assign accept   = in_valid && in_ready;

    // a frame-first pixel always lands at the origin
    assign pix_x = in_first ? '0 : cur_x;
    assign pix_y = in_first ? '0 : cur_y;

    assign take      = accept && (in_first || state == WR_FILL);
    assign line_end  = in_last || pix_x == POS_BITS'(IMG_W - 1);
    assign frame_end = pix_x == POS_BITS'(IMG_W - 1) && pix_y == POS_BITS'(IMG_H - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= WR_WAIT_FIRST;
            cur_x         <= '0;
            cur_y         <= '0;
            mem.wr_en     <= 1'b0;
            frame_written <= 1'b0;
        end else begin
            mem.wr_en     <= take;
            frame_written <= take && frame_end;     // same cycle as the (15,15) write
            if (take) begin
                if (frame_end) begin
                    state <= WR_WAIT_FIRST;
                    cur_x <= '0;
                    cur_y <= '0;
                end else begin
                    state <= WR_FILL;
                    if (line_end) begin
                        cur_x <= '0;
                        cur_y <= pix_y + 1'b1;
                    end else begin
                        cur_x <= pix_x + 1'b1;
                        cur_y <= pix_y;
                    end
                end
            end
        end
    end

    // write port payload
    always_ff @(posedge clk) begin
        if (take) begin
            mem.wr_addr <= tile_addr(int'(pix_x), int'(pix_y));
            mem.wr_data <= in_data;
        end
    end

    // line-last must line up with the right edge of the raster
    a_last_at_edge: assert property (@(posedge clk) disable iff (reset)
        accept && in_last && state == WR_FILL && !in_first |-> cur_x == POS_BITS'(IMG_W - 1));

endmodule

`default_nettype wire

//--- rtl/texture_mem.sv
`timescale 1ns/1ps
`default_nettype none

module texture_mem
    import tex_pkg::*;
(
    input  wire       clk,
    tex_mem_if.mem    mem
);

    pixel_t ram [2**ADDR_BITS];

    always_ff @(posedge clk) begin
        if (mem.wr_en) begin
            ram[mem.wr_addr] <= mem.wr_data;
        end
        if (mem.rd_en) begin
            mem.rd_data <= ram[mem.rd_addr];    // holds while rd_en is low
        end
    end

    // writer and sampler never touch the same texel in one cycle
    a_no_collision: assert property (@(posedge clk)
        !(mem.wr_en && mem.rd_en && mem.wr_addr == mem.rd_addr));

endmodule

`default_nettype wire

//--- rtl/affine_coord_gen.sv
`timescale 1ns/1ps
`default_nettype none

module affine_coord_gen
    import tex_pkg::*;
(
    input  wire           clk,
    input  wire           reset,

    input  wire           frame_written,
    output logic          sampling_busy,

    input  coeff_t        m00,
    input  coeff_t        m01,
    input  coeff_t        m10,
    input  coeff_t        m11,
    input  offset_t       m02,
    input  offset_t       m12,

    coord_if.producer     coord
);

    gen_state_t state;
    pos_t       x_cnt;
    pos_t       y_cnt;
    logic       xfer;
    logic       at_last;

    logic signed [POS_BITS:0] xs;
    logic signed [POS_BITS:0] ys;
    logic signed [15:0]       u_sum;
    logic signed [15:0]       v_sum;

    // --------------------------------------------------
    //  affine transform of the output position
    // --------------------------------------------------
    assign xs = $signed({1'b0, x_cnt});
    assign ys = $signed({1'b0, y_cnt});

    assign u_sum = m00 * xs + m01 * ys + m02;
    assign v_sum = m10 * xs + m11 * ys + m12;

    assign coord.u = coord_t'(u_sum);
    assign coord.v = coord_t'(v_sum);

    assign at_last       = x_cnt == POS_BITS'(IMG_W - 1) && y_cnt == POS_BITS'(IMG_H - 1);
    assign coord.last    = at_last;
    assign coord.valid   = state == GEN_RUN;
    assign sampling_busy = state == GEN_RUN;
    assign xfer          = coord.valid && coord.ready;

    // --------------------------------------------------
    //  raster walk
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= GEN_IDLE;
            x_cnt <= '0;
            y_cnt <= '0;
        end else begin
            case (state)
                GEN_IDLE: begin
                    x_cnt <= '0;
                    y_cnt <= '0;
                    if (frame_written) state <= GEN_RUN;
                end
                GEN_RUN: begin
                    if (xfer) begin
                        if (at_last) begin
                            state <= GEN_IDLE;
                        end else if (x_cnt == POS_BITS'(IMG_W - 1)) begin
                            x_cnt <= '0;
                            y_cnt <= y_cnt + 1'b1;
                        end else begin
                            x_cnt <= x_cnt + 1'b1;
                        end
                    end
                end
                default: state <= GEN_IDLE;
            endcase
        end
    end

    a_hold_coord: assert property (@(posedge clk) disable iff (reset)
        coord.valid && !coord.ready |=> coord.valid && $stable(coord.u) && $stable(coord.v));

endmodule

`default_nettype wire

//--- rtl/texture_sampler.sv
`timescale 1ns/1ps
`default_nettype none

module texture_sampler
    import tex_pkg::*;
(
    input  wire           clk,
    input  wire           reset,

    coord_if.consumer     coord,
    tex_mem_if.reader     mem,

    input  pixel_t        border_value,

    output pixel_t        out_data,
    output logic          out_border,
    output logic          out_last,
    output logic          out_valid,
    input  wire           out_ready
);

    // upper bits of the 8.4 coordinates give the floor
    logic signed [$bits(coord_t)-FRAC_BITS-1:0] u_int;
    logic signed [$bits(coord_t)-FRAC_BITS-1:0] v_int;

    logic advance;
    logic take;
    logic border_in;

    logic s1_valid;
    logic s1_border;
    logic s1_last;

    // --------------------------------------------------
    //  stage 1: floor, border test, read issue
    // --------------------------------------------------
    assign u_int = coord.u[$bits(coord_t)-1:FRAC_BITS];
    assign v_int = coord.v[$bits(coord_t)-1:FRAC_BITS];

    assign border_in = u_int < 0 || u_int > IMG_W - 1 ||
                       v_int < 0 || v_int > IMG_H - 1;

    // pipeline moves only when the output slot is free
    assign advance     = !out_valid || out_ready;
    assign coord.ready = advance;
    assign take        = coord.valid && advance;

    assign mem.rd_en   = take && !border_in;   // no fetch for border texels
    assign mem.rd_addr = tile_addr(int'(u_int), int'(v_int));

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else if (advance) begin
            s1_valid  <= coord.valid;
            out_valid <= s1_valid;
        end
    end

    // --------------------------------------------------
    //  stage 2: output register
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (advance) begin
            s1_border  <= border_in;
            s1_last    <= coord.last;
            out_data   <= s1_border ? border_value : mem.rd_data;
            out_border <= s1_border;
            out_last   <= s1_last;
        end
    end

    // a stalled beat and the texel read behind it both hold
    a_out_stall: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(mem.rd_data));

endmodule

`default_nettype wire

//--- rtl/affine_remap_top.sv
`timescale 1ns/1ps
`default_nettype none

module affine_remap_top
    import tex_pkg::*;
(
    input  wire       clk,
    input  wire       reset,

    // pixel stream in
    input  pixel_t    in_data,
    input  wire       in_first,
    input  wire       in_last,
    input  wire       in_valid,
    output logic      in_ready,

    // affine matrix
    input  coeff_t    m00,
    input  coeff_t    m01,
    input  coeff_t    m10,
    input  coeff_t    m11,
    input  offset_t   m02,
    input  offset_t   m12,

    input  pixel_t    border_value,

    // remapped stream out
    output pixel_t    out_data,
    output logic      out_border,
    output logic      out_last,
    output logic      out_valid,
    input  wire       out_ready
);

    logic frame_written;
    logic sampling_busy;

    tex_mem_if mem_bus ();
    coord_if   coord_bus ();

    // --------------------------------------------------
    //  texture fill
    // --------------------------------------------------
    texture_writer u_writer (
        .clk           (clk),
        .reset         (reset),
        .in_data       (in_data),
        .in_first      (in_first),
        .in_last       (in_last),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .sampling_busy (sampling_busy),
        .frame_written (frame_written),
        .mem           (mem_bus.writer)
    );

    texture_mem u_mem (
        .clk (clk),
        .mem (mem_bus.mem)
    );

    // --------------------------------------------------
    //  sampling path
    // --------------------------------------------------
    affine_coord_gen u_coord_gen (
        .clk           (clk),
        .reset         (reset),
        .frame_written (frame_written),
        .sampling_busy (sampling_busy),
        .m00           (m00),
        .m01           (m01),
        .m10           (m10),
        .m11           (m11),
        .m02           (m02),
        .m12           (m12),
        .coord         (coord_bus.producer)
    );

    texture_sampler u_sampler (
        .clk          (clk),
        .reset        (reset),
        .coord        (coord_bus.consumer),
        .mem          (mem_bus.reader),
        .border_value (border_value),
        .out_data     (out_data),
        .out_border   (out_border),
        .out_last     (out_last),
        .out_valid    (out_valid),
        .out_ready    (out_ready)
    );

endmodule

`default_nettype wire

//--- verif/affine_remap_tb.sv
`timescale 1ns/1ps
`default_nettype none

module affine_remap_tb
    import tex_pkg::*;
;

    localparam int          NUM_ROWS       = 8;
    localparam int          NPIX           = IMG_W * IMG_H;
    localparam int          TIMEOUT_CYCLES = NUM_ROWS * 1200;
    localparam logic [31:0] SEED           = 32'h86dc_9bae;

    // one test case with matrix, border value and out_ready busy rate in percent
    typedef struct packed {
        logic signed [7:0]  m00;
        logic signed [7:0]  m01;
        logic signed [7:0]  m10;
        logic signed [7:0]  m11;
        logic signed [11:0] m02;
        logic signed [11:0] m12;
        logic [7:0]         border;
        logic [7:0]         busy;
    } row_t;

    logic    clk = 1'b0;
    logic    reset;
    pixel_t  in_data;
    logic    in_first;
    logic    in_last;
    logic    in_valid;
    logic    in_ready;
    coeff_t  m00;
    coeff_t  m01;
    coeff_t  m10;
    coeff_t  m11;
    offset_t m02;
    offset_t m12;
    pixel_t  border_value;
    pixel_t  out_data;
    logic    out_border;
    logic    out_last;
    logic    out_valid;
    logic    out_ready;

    row_t    rows [NUM_ROWS];
    pixel_t  image [NPIX];      // kept in raster order
    int      cycle_count = 0;

    always #2 clk = ~clk;

    affine_remap_top UUT (
        .clk          (clk),
        .reset        (reset),
        .in_data      (in_data),
        .in_first     (in_first),
        .in_last      (in_last),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .m00          (m00),
        .m01          (m01),
        .m10          (m10),
        .m11          (m11),
        .m02          (m02),
        .m12          (m12),
        .border_value (border_value),
        .out_data     (out_data),
        .out_border   (out_border),
        .out_last     (out_last),
        .out_valid    (out_valid),
        .out_ready    (out_ready)
    );

    // --------------------------------------------------
    //  stimulus table
    // --------------------------------------------------
    task automatic load_table();
        rows[0] = '{8'sd16, 8'sd0, 8'sd0, 8'sd16, 12'sd0, 12'sd0, 8'h00, 8'd0};     // identity
        rows[1] = '{8'sd16, 8'sd0, 8'sd0, 8'sd16, 12'sd0, 12'sd0, 8'h00, 8'd30};
        rows[2] = '{8'sd16, 8'sd0, 8'sd0, 8'sd16, 12'sd48, -12'sd32, 8'ha5, 8'd0};  // +3, -2
        rows[3] = '{8'sd8, 8'sd0, 8'sd0, 8'sd8, 12'sd0, 12'sd0, 8'h5a, 8'd20};      // scale 0.5
        rows[4] = '{8'sd11, -8'sd11, 8'sd11, 8'sd11, 12'sd64, -12'sd48, 8'hc3, 8'd40};
        rows[5] = '{8'sd16, 8'sd0, 8'sd0, 8'sd16, -12'sd24, 12'sd8, 8'h3c, 8'd25};  // -1.5, +0.5
        rows[6] = '{8'sd32, 8'sd0, 8'sd0, 8'sd32, 12'sd0, 12'sd0, 8'hff, 8'd50};    // scale 2
        rows[7] = '{-8'sd16, 8'sd0, 8'sd0, -8'sd16, 12'sd240, 12'sd240, 8'h81, 8'd10};
    endtask

    task automatic fail_value(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        $display("Checks failed");
        $fatal(1, "stopped at first error");
    endtask

    // floored nearest texel or the border value outside 0..15
    function automatic void model_sample(input row_t cfg, input int x, input int y,
                                         output pixel_t pix, output logic border);
        int                 u_full;
        int                 v_full;
        logic signed [11:0] u12;
        logic signed [11:0] v12;
        int                 ui;
        int                 vi;
        u_full = int'(cfg.m00) * x + int'(cfg.m01) * y + int'(cfg.m02);
        v_full = int'(cfg.m10) * x + int'(cfg.m11) * y + int'(cfg.m12);
        u12 = u_full[11:0];     // coord_t truncation
        v12 = v_full[11:0];
        ui = int'(u12) >>> FRAC_BITS;
        vi = int'(v12) >>> FRAC_BITS;
        border = ui < 0 || ui > IMG_W - 1 || vi < 0 || vi > IMG_H - 1;
        pix = border ? cfg.border : image[vi * IMG_W + ui];
    endfunction

    task automatic fill_image();
        for (int i = 0; i < NPIX; i++) begin
            image[i] = pixel_t'($urandom());
        end
    endtask

    // --------------------------------------------------
    //  input and output streams
    // --------------------------------------------------
    task automatic write_image();
        for (int i = 0; i < NPIX; i++) begin
            in_valid <= 1'b1;
            in_data  <= image[i];
            in_first <= (i == 0);
            in_last  <= (i % IMG_W == IMG_W - 1);
            @(posedge clk);
            assert (!out_valid) else fail_value("out_valid high while the image is written");
            while (!in_ready) begin
                @(posedge clk);
            end
        end
        in_valid <= 1'b0;
        in_first <= 1'b0;
        in_last  <= 1'b0;
    endtask

    task automatic collect_outputs(input row_t cfg);
        int     count;
        int     x;
        int     y;
        pixel_t exp_pix;
        logic   exp_border;
        count = 0;
        while (count < NPIX) begin
            out_ready <= ($urandom_range(99) >= cfg.busy);
            @(posedge clk);
            if (out_valid && out_ready) begin
                x = count % IMG_W;
                y = count / IMG_W;
                model_sample(cfg, x, y, exp_pix, exp_border);
                assert (out_data == exp_pix) else fail_value($sformatf(
                    "out_data at (%0d,%0d) is %02h, expected %02h", x, y, out_data, exp_pix));
                assert (out_border == exp_border) else fail_value($sformatf(
                    "out_border at (%0d,%0d) is %0b, expected %0b", x, y, out_border, exp_border));
                assert (out_last == (count == NPIX - 1)) else fail_value($sformatf(
                    "out_last is %0b on output %0d", out_last, count));
                // only the last two outputs can still sit in the sampler once the generator is done
                if (count < NPIX - 2) begin
                    assert (!in_ready) else fail_value($sformatf(
                        "in_ready high on output %0d while the frame is pending", count));
                end
                count++;
            end
        end
        out_ready <= 1'b1;
    endtask

    task automatic run_row(input int r);
        row_t cfg;
        cfg = rows[r];
        m00          <= cfg.m00;
        m01          <= cfg.m01;
        m10          <= cfg.m10;
        m11          <= cfg.m11;
        m02          <= cfg.m02;
        m12          <= cfg.m12;
        border_value <= cfg.border;
        fill_image();   // a fresh image per row exposes a stale texture
        write_image();
        collect_outputs(cfg);
    endtask

    // --------------------------------------------------
    //  main sequence and timeout
    // --------------------------------------------------
    initial begin
        void'($urandom(SEED));
        reset        = 1'b1;
        in_data      = '0;
        in_first     = 1'b0;
        in_last      = 1'b0;
        in_valid     = 1'b0;
        m00          = '0;
        m01          = '0;
        m10          = '0;
        m11          = '0;
        m02          = '0;
        m12          = '0;
        border_value = '0;
        out_ready    = 1'b1;
        load_table();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        assert (in_ready && !out_valid) else fail_value("in_ready or out_valid wrong after reset");
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        $display("All checks passed");
        $finish;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $fatal(1, "timeout");
        end
    end

endmodule

`default_nettype wire

//--- affine_remap.f
rtl/tex_pkg.sv
rtl/tex_mem_if.sv
rtl/coord_if.sv
rtl/texture_writer.sv
rtl/texture_mem.sv
rtl/affine_coord_gen.sv
rtl/texture_sampler.sv
rtl/affine_remap_top.sv
verif/affine_remap_tb.sv

//--- Makefile
TOP := affine_remap_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -Wno-fatal \
		--top-module $(TOP) -f affine_remap.f -o V$(TOP)

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing -Wall --top-module affine_remap_top \
		rtl/tex_pkg.sv rtl/tex_mem_if.sv rtl/coord_if.sv rtl/texture_writer.sv \
		rtl/texture_mem.sv rtl/affine_coord_gen.sv rtl/texture_sampler.sv \
		rtl/affine_remap_top.sv

clean:
	rm -rf obj_dir
